//--- verilog/ice_bus_pkg.sv
package ice_bus_pkg;

	// Pin count of the GPIO block
	localparam int GPIO_WIDTH = 8;

	// Frame type codes, ASCII letters on the host link
	localparam logic [7:0] TYPE_VERSION    = 8'h56;
	localparam logic [7:0] TYPE_POWER      = 8'h50;
	localparam logic [7:0] TYPE_GPIO_WRITE = 8'h67;
	localparam logic [7:0] TYPE_GPIO_READ  = 8'h47;
	localparam logic [7:0] TYPE_GPIO_EVENT = 8'h65;
	localparam logic [7:0] TYPE_NAK        = 8'h4E;

	// Returned by a version query
	localparam logic [7:0] VERSION_MAJOR = 8'h01;
	localparam logic [7:0] VERSION_MINOR = 8'h04;

	// Broadcast from the bus controller to every responder
	typedef struct packed {
		logic [7:0] type_code;
		logic [7:0] data;
		logic       data_valid;
		logic       frame_valid;
	} ma_bus_t;

	// Reply request from one responder slot to the arbiter
	typedef struct packed {
		logic       request;
		logic [7:0] type_code;
		logic [7:0] len;
	} sl_req_t;

	// One queued pin-change event
	typedef struct packed {
		logic [GPIO_WIDTH-1:0] pins;
	} gpio_event_t;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  T     push_data,
	input  logic pop,
	output T     pop_data,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;

	// Head entry visible without a pop
	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (AW + 1)'(DEPTH));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the fill level alone
			count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
		end
	end

	assert property (@(posedge clk) disable iff (reset) push |-> !full);
	assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

//--- verilog/ice_bus_controller.sv
`timescale 1ns/1ps

module ice_bus_controller (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           host_rx_data,
	input  logic                 host_rx_valid,
	output logic                 host_rx_ready,
	input  logic                 resp_busy,
	output ice_bus_pkg::ma_bus_t ma,
	output ice_bus_pkg::sl_req_t nak_req,
	input  logic                 nak_grant,
	input  logic                 nak_take,
	output logic [7:0]           nak_data
);

	typedef enum logic [1:0] {RX_HDR, RX_LEN, RX_PAY} rx_state_t;
	typedef enum logic [2:0] {P_HDR, P_LEN, P_PAY, P_END, P_WAIT} p_state_t;

	rx_state_t rx_state;
	p_state_t state;
	logic [7:0] rx_rem;
	logic [7:0] fifo_head;
	logic fifo_empty;
	logic fifo_full;
	logic push;
	logic pop;
	logic head_is_cmd;
	logic known;
	logic [7:0] type_q;
	logic [7:0] remaining;
	logic [1:0] wait_cnt;
	logic nak_pending;

	// Input side tracks frame boundaries so stalls hit only headers
	assign host_rx_ready = !fifo_full && !((rx_state == RX_HDR) && resp_busy);
	assign push = host_rx_valid && host_rx_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state <= RX_HDR;
			rx_rem <= '0;
		end else if (push) begin
			case (rx_state)
				RX_HDR: rx_state <= RX_LEN;
				RX_LEN: begin
					rx_rem <= host_rx_data;
					rx_state <= (host_rx_data == 8'd0) ? RX_HDR : RX_PAY;
				end
				default: begin
					rx_rem <= rx_rem - 1'b1;
					if (rx_rem == 8'd1) begin
						rx_state <= RX_HDR;
					end
				end
			endcase
		end
	end

	sync_fifo #(
		.T(logic [7:0]),
		.DEPTH(4)
	) u_rx_fifo (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_data(host_rx_data),
		.pop(pop),
		.pop_data(fifo_head),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	// Only the four command codes get broadcast
	assign head_is_cmd = (fifo_head == ice_bus_pkg::TYPE_VERSION) ||
		(fifo_head == ice_bus_pkg::TYPE_POWER) ||
		(fifo_head == ice_bus_pkg::TYPE_GPIO_WRITE) ||
		(fifo_head == ice_bus_pkg::TYPE_GPIO_READ);

	// New header waits for the previous reply to drain
	assign pop = !fifo_empty && (((state == P_HDR) && !resp_busy) ||
		(state == P_LEN) || (state == P_PAY));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= P_HDR;
			known <= 1'b0;
			remaining <= '0;
			wait_cnt <= '0;
			nak_pending <= 1'b0;
		end else begin
			case (state)
				P_HDR: begin
					if (pop) begin
						known <= head_is_cmd;
						state <= P_LEN;
					end
				end
				P_LEN: begin
					if (pop) begin
						remaining <= fifo_head;
						state <= (fifo_head == 8'd0) ? P_END : P_PAY;
					end
				end
				P_PAY: begin
					if (pop) begin
						remaining <= remaining - 1'b1;
						if (remaining == 8'd1) begin
							state <= P_END;
						end
					end
				end
				P_END: begin
					if (!known) begin
						nak_pending <= 1'b1;
					end
					wait_cnt <= 2'd1;
					state <= P_WAIT;
				end
				default: begin
					// Covers the gap until a responder request shows up
					if (wait_cnt == 2'd0) begin
						state <= P_HDR;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
			endcase
			// NAK carries one byte, so one take ends it
			if (nak_pending && nak_grant && nak_take) begin
				nak_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == P_HDR) && pop) begin
			type_q <= fifo_head;
		end
	end

	always_comb begin
		ma.type_code = type_q;
		ma.data = fifo_head;
		ma.frame_valid = known && ((state == P_LEN) || (state == P_PAY) || (state == P_END));
		ma.data_valid = known && (state == P_PAY) && !fifo_empty;
	end

	assign nak_req = '{request: nak_pending, type_code: ice_bus_pkg::TYPE_NAK, len: 8'd1};
	// Offending type byte, held until the NAK is sent
	assign nak_data = type_q;

endmodule

//--- verilog/basics_int.sv
`timescale 1ns/1ps

module basics_int (
	input  logic                 clk,
	input  logic                 reset,
	input  ice_bus_pkg::ma_bus_t ma,
	output ice_bus_pkg::sl_req_t sl_req,
	input  logic                 sl_grant,
	input  logic                 sl_take,
	output logic [7:0]           sl_data,
	output logic [2:0]           power_sw
);

	logic own_type;
	logic mine;
	logic fv_d;
	logic fall_q;
	logic [7:0] cur_type;
	logic [7:0] nbytes;
	logic [7:0] first_byte;
	logic idx;

	assign own_type = (ma.type_code == ice_bus_pkg::TYPE_VERSION) ||
		(ma.type_code == ice_bus_pkg::TYPE_POWER);

	always_ff @(posedge clk) begin
		if (ma.frame_valid && own_type) begin
			cur_type <= ma.type_code;
		end
		if (ma.data_valid && (nbytes == 8'd0)) begin
			first_byte <= ma.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mine <= 1'b0;
			fv_d <= 1'b0;
			fall_q <= 1'b0;
			nbytes <= '0;
			idx <= 1'b0;
			sl_req <= '0;
			power_sw <= '0;
		end else begin
			fv_d <= ma.frame_valid;
			if (ma.frame_valid) begin
				mine <= own_type;
			end
			// Act one cycle after frame_valid drops
			fall_q <= fv_d && !ma.frame_valid && mine;
			if (ma.frame_valid && !fv_d) begin
				nbytes <= '0;
			end else if (ma.data_valid) begin
				nbytes <= nbytes + 1'b1;
			end
			if (fall_q) begin
				idx <= 1'b0;
				if (cur_type == ice_bus_pkg::TYPE_VERSION) begin
					sl_req <= '{request: 1'b1, type_code: cur_type, len: 8'd2};
				end else begin
					sl_req <= '{request: 1'b1, type_code: cur_type, len: 8'd0};
					// Bad length still gets an ack, switches stay put
					if (nbytes == 8'd1) begin
						power_sw <= first_byte[2:0];
					end
				end
			end else if (sl_req.request && sl_grant) begin
				if (sl_req.len == 8'd0) begin
					sl_req.request <= 1'b0;
				end else if (sl_take) begin
					idx <= idx + 1'b1;
					if ({7'd0, idx} == sl_req.len - 8'd1) begin
						sl_req.request <= 1'b0;
					end
				end
			end
		end
	end

	// Major first, then minor
	assign sl_data = idx ? ice_bus_pkg::VERSION_MINOR : ice_bus_pkg::VERSION_MAJOR;

	// Arbiter relies on type and length holding while it waits
	assert property (@(posedge clk) disable iff (reset)
		sl_req.request && !sl_grant |=> sl_req.request && $stable(sl_req));

endmodule

//--- verilog/gpio_int.sv
`timescale 1ns/1ps

module gpio_int (
	input  logic                                clk,
	input  logic                                reset,
	input  ice_bus_pkg::ma_bus_t                ma,
	input  logic [ice_bus_pkg::GPIO_WIDTH-1:0]  gpio_in,
	output logic [ice_bus_pkg::GPIO_WIDTH-1:0]  gpio_out,
	output logic [ice_bus_pkg::GPIO_WIDTH-1:0]  gpio_oe,
	output ice_bus_pkg::sl_req_t                sl_req,
	input  logic                                sl_grant,
	input  logic                                sl_take,
	output logic [7:0]                          sl_data
);

	logic [ice_bus_pkg::GPIO_WIDTH-1:0] sync_a, sync_b, prev, int_en, pend_byte;
	logic [7:0] pay [3];
	logic [7:0] cur_type;
	logic [7:0] nbytes;
	logic own_type, mine, fv_d, fall_q;
	logic cmd_pend;
	logic evt_push, evt_pop, evt_empty, evt_full;
	ice_bus_pkg::gpio_event_t evt_head;
	ice_bus_pkg::sl_req_t cmd_req;

	assign own_type = (ma.type_code == ice_bus_pkg::TYPE_GPIO_WRITE) ||
		(ma.type_code == ice_bus_pkg::TYPE_GPIO_READ);

	// Two-stage sync, then edge compare on enabled pins
	always_ff @(posedge clk) begin
		sync_a <= gpio_in;
		sync_b <= sync_a;
		prev <= sync_b;
		if (ma.frame_valid && own_type) cur_type <= ma.type_code;
		if (ma.data_valid && (nbytes < 8'd3)) pay[nbytes[1:0]] <= ma.data;
		if (fall_q) pend_byte <= sync_b;
		// Reply byte follows whatever gets loaded into the slot
		if (!sl_req.request) sl_data <= fall_q ? sync_b : (cmd_pend ? pend_byte : evt_head.pins);
	end

	assign evt_push = (|((sync_b ^ prev) & int_en)) && !evt_full;
	// Command replies take the slot before queued events
	assign evt_pop = !sl_req.request && !fall_q && !cmd_pend && !evt_empty;
	assign cmd_req = '{request: 1'b1, type_code: cur_type,
		len: (cur_type == ice_bus_pkg::TYPE_GPIO_READ) ? 8'd1 : 8'd0};

	sync_fifo #(
		.T(ice_bus_pkg::gpio_event_t),
		.DEPTH(4)
	) u_evt_fifo (
		.clk(clk),
		.reset(reset),
		.push(evt_push),
		.push_data(ice_bus_pkg::gpio_event_t'(sync_b)),
		.pop(evt_pop),
		.pop_data(evt_head),
		.empty(evt_empty),
		.full(evt_full)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			{mine, fv_d, fall_q, cmd_pend} <= '0;
			nbytes <= '0;
			sl_req <= '0;
			{gpio_out, gpio_oe, int_en} <= '0;
		end else begin
			fv_d <= ma.frame_valid;
			if (ma.frame_valid) mine <= own_type;
			fall_q <= fv_d && !ma.frame_valid && mine;
			if (ma.frame_valid && !fv_d) nbytes <= '0;
			else if (ma.data_valid) nbytes <= nbytes + 1'b1;
			// Level, direction, enable in payload order
			if (fall_q && (cur_type == ice_bus_pkg::TYPE_GPIO_WRITE) && (nbytes == 8'd3)) begin
				gpio_out <= pay[0];
				gpio_oe <= pay[1];
				int_en <= pay[2];
			end
			if (fall_q && sl_req.request) cmd_pend <= 1'b1;
			if (sl_req.request) begin
				// Every reply here is at most one byte long
				if (sl_grant && ((sl_req.len == 8'd0) || sl_take)) sl_req.request <= 1'b0;
			end else if (fall_q) begin
				sl_req <= cmd_req;
			end else if (cmd_pend) begin
				sl_req <= cmd_req;
				cmd_pend <= 1'b0;
			end else if (!evt_empty) begin
				sl_req <= '{request: 1'b1, type_code: ice_bus_pkg::TYPE_GPIO_EVENT, len: 8'd1};
			end
		end
	end

endmodule

//--- verilog/response_arbiter.sv
`timescale 1ns/1ps

module response_arbiter #(
	parameter int NUM_RESP = 3
) (
	input  logic                 clk,
	input  logic                 reset,
	input  ice_bus_pkg::sl_req_t req [NUM_RESP],
	output logic [NUM_RESP-1:0]  grant,
	output logic [NUM_RESP-1:0]  take,
	input  logic [7:0]           data [NUM_RESP],
	output logic                 resp_busy,
	output logic [7:0]           host_tx_data,
	output logic                 host_tx_valid,
	output logic                 host_tx_last,
	input  logic                 host_tx_ready
);

	localparam int SEL_W = (NUM_RESP > 1) ? $clog2(NUM_RESP) : 1;

	typedef enum logic [2:0] {S_IDLE, S_TYPE, S_EVT, S_LEN, S_PAY} state_t;

	state_t state;
	logic [SEL_W-1:0] sel;
	logic [SEL_W-1:0] pick;
	logic any_req;
	logic [7:0] type_q;
	logic [7:0] len_q;
	logic [7:0] cnt;
	logic [7:0] evt_num;
	logic accept;

	// Lowest index wins
	always_comb begin
		any_req = 1'b0;
		pick = '0;
		for (int i = NUM_RESP - 1; i >= 0; i--) begin
			if (req[i].request) begin
				any_req = 1'b1;
				pick = SEL_W'(i);
			end
		end
	end

	// Header is type, event number, length
	always_comb begin
		host_tx_valid = (state != S_IDLE);
		host_tx_last = 1'b0;
		take = '0;
		case (state)
			S_TYPE: host_tx_data = type_q;
			S_EVT: host_tx_data = evt_num;
			S_LEN: begin
				host_tx_data = len_q;
				host_tx_last = (len_q == 8'd0);
			end
			S_PAY: begin
				host_tx_data = data[sel];
				host_tx_last = (cnt == len_q - 8'd1);
				take[sel] = host_tx_ready;
			end
			default: host_tx_data = 8'h00;
		endcase
	end

	assign accept = host_tx_valid && host_tx_ready;
	assign resp_busy = any_req || (state != S_IDLE);

	always_ff @(posedge clk) begin
		if ((state == S_IDLE) && any_req) begin
			type_q <= req[pick].type_code;
			len_q <= req[pick].len;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			grant <= '0;
			sel <= '0;
			cnt <= '0;
			evt_num <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (any_req) begin
						grant <= NUM_RESP'(1) << pick;
						sel <= pick;
						state <= S_TYPE;
					end
				end
				S_TYPE: if (accept) state <= S_EVT;
				S_EVT: if (accept) state <= S_LEN;
				S_LEN: begin
					cnt <= '0;
					if (accept) state <= S_PAY;
				end
				default: if (accept) cnt <= cnt + 1'b1;
			endcase
			// Last byte out releases the slot and bumps the event number
			if (accept && host_tx_last) begin
				grant <= '0;
				evt_num <= evt_num + 1'b1;
				state <= S_IDLE;
			end
		end
	end

	// Stalled byte holds, including the payload byte the responder presents
	assert property (@(posedge clk) disable iff (reset)
		host_tx_valid && !host_tx_ready |=>
			host_tx_valid && $stable(host_tx_data) && $stable(host_tx_last));

endmodule

//--- verilog/ice_bus.sv
`timescale 1ns/1ps

module ice_bus (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [7:0]                         host_rx_data,
	input  logic                               host_rx_valid,
	output logic                               host_rx_ready,
	output logic [7:0]                         host_tx_data,
	output logic                               host_tx_valid,
	output logic                               host_tx_last,
	input  logic                               host_tx_ready,
	output logic [2:0]                         power_sw,
	input  logic [ice_bus_pkg::GPIO_WIDTH-1:0] gpio_in,
	output logic [ice_bus_pkg::GPIO_WIDTH-1:0] gpio_out,
	output logic [ice_bus_pkg::GPIO_WIDTH-1:0] gpio_oe
);

	localparam int NUM_RESP = 3;

	// Slot 0 NAK, slot 1 basics, slot 2 GPIO
	ice_bus_pkg::ma_bus_t ma;
	ice_bus_pkg::sl_req_t req [NUM_RESP];
	logic [7:0] resp_data [NUM_RESP];
	logic [NUM_RESP-1:0] grant;
	logic [NUM_RESP-1:0] take;
	logic resp_busy;

	ice_bus_controller u_ctrl (
		.clk(clk), .reset(reset),
		.host_rx_data(host_rx_data), .host_rx_valid(host_rx_valid),
		.host_rx_ready(host_rx_ready), .resp_busy(resp_busy), .ma(ma),
		.nak_req(req[0]), .nak_grant(grant[0]), .nak_take(take[0]), .nak_data(resp_data[0])
	);

	basics_int u_basics (
		.clk(clk), .reset(reset), .ma(ma),
		.sl_req(req[1]), .sl_grant(grant[1]), .sl_take(take[1]), .sl_data(resp_data[1]),
		.power_sw(power_sw)
	);

	gpio_int u_gpio (
		.clk(clk), .reset(reset), .ma(ma),
		.gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe),
		.sl_req(req[2]), .sl_grant(grant[2]), .sl_take(take[2]), .sl_data(resp_data[2])
	);

	response_arbiter #(
		.NUM_RESP(NUM_RESP)
	) u_arb (
		.clk(clk), .reset(reset),
		.req(req), .grant(grant), .take(take), .data(resp_data), .resp_busy(resp_busy),
		.host_tx_data(host_tx_data), .host_tx_valid(host_tx_valid),
		.host_tx_last(host_tx_last), .host_tx_ready(host_tx_ready)
	);

endmodule

//--- sim/ice_bus_tb.sv
`timescale 1ns/1ps

module ice_bus_tb;

	// Cycles allowed for any single wait
	localparam int TIMEOUT = 400;
	// Window in which no event frame may show up
	localparam int QUIET_CYCLES = 60;

	logic clk;
	logic reset;
	logic [7:0] host_rx_data;
	logic host_rx_valid;
	logic host_rx_ready;
	logic [7:0] host_tx_data;
	logic host_tx_valid;
	logic host_tx_last;
	logic host_tx_ready;
	logic [2:0] power_sw;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;
	logic [7:0] gpio_oe;

	// Payload to send, last frame received, payload expected back
	logic [7:0] tx_bytes [$];
	logic [7:0] rx_bytes [$];
	logic [7:0] exp_pay [$];
	// Event number the next reply frame should carry
	logic [7:0] exp_evt;
	logic [15:0] lfsr;
	// Random host_tx_ready when set
	logic bp_mode;

	ice_bus u_ice_bus (
		.clk(clk),
		.reset(reset),
		.host_rx_data(host_rx_data),
		.host_rx_valid(host_rx_valid),
		.host_rx_ready(host_rx_ready),
		.host_tx_data(host_tx_data),
		.host_tx_valid(host_tx_valid),
		.host_tx_last(host_tx_last),
		.host_tx_ready(host_tx_ready),
		.power_sw(power_sw),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	// One LFSR step per ready bit
	task automatic update_tx_ready();
		if (bp_mode) begin
			lfsr = lfsr_next(lfsr);
			host_tx_ready = lfsr[0];
		end else begin
			host_tx_ready = 1'b1;
		end
	endtask

	// Called and returns just after a rising edge
	task automatic push_byte(input logic [7:0] b);
		int n;
		n = 0;
		host_rx_data = b;
		host_rx_valid = 1'b1;
		@(negedge clk);
		while (!host_rx_ready) begin
			n++;
			if (n > TIMEOUT) begin
				fail_timeout("host_rx_ready");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		host_rx_valid = 1'b0;
	endtask

	// Type, length, then the bytes in tx_bytes
	task automatic send_frame(input logic [7:0] type_code);
		push_byte(type_code);
		push_byte(8'(tx_bytes.size()));
		foreach (tx_bytes[i]) begin
			push_byte(tx_bytes[i]);
		end
	endtask

	task automatic get_frame();
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		rx_bytes.delete();
		update_tx_ready();
		while (!done) begin
			@(negedge clk);
			if (host_tx_valid && host_tx_ready) begin
				rx_bytes.push_back(host_tx_data);
				done = host_tx_last;
			end
			n++;
			if (n > TIMEOUT) begin
				fail_timeout("a reply frame on host_tx");
			end
			@(posedge clk);
			#1;
			update_tx_ready();
		end
		// Replies wait in the arbiter until the next collect
		host_tx_ready = 1'b0;
	endtask

	// Header is type, event number, length
	task automatic expect_frame(input logic [7:0] type_code);
		get_frame();
		check_eq("frame size", rx_bytes.size(), exp_pay.size() + 3);
		check_eq("reply type", rx_bytes[0], type_code);
		check_eq("event number", rx_bytes[1], exp_evt);
		check_eq("reply length", rx_bytes[2], exp_pay.size());
		foreach (exp_pay[i]) begin
			check_eq("reply payload", rx_bytes[i + 3], exp_pay[i]);
		end
		exp_evt = exp_evt + 8'd1;
	endtask

	task automatic version_query();
		tx_bytes.delete();
		send_frame(ice_bus_pkg::TYPE_VERSION);
		exp_pay.delete();
		exp_pay.push_back(ice_bus_pkg::VERSION_MAJOR);
		exp_pay.push_back(ice_bus_pkg::VERSION_MINOR);
		expect_frame(ice_bus_pkg::TYPE_VERSION);
	endtask

	task automatic power_switch();
		// Upper bits are ignored by the switch register
		tx_bytes.delete();
		tx_bytes.push_back(8'hF5);
		send_frame(ice_bus_pkg::TYPE_POWER);
		exp_pay.delete();
		expect_frame(ice_bus_pkg::TYPE_POWER);
		check_eq("power_sw", power_sw, 3'd5);
	endtask

	task automatic write_gpio(input logic [7:0] level, input logic [7:0] dir,
		input logic [7:0] en);
		tx_bytes.delete();
		tx_bytes.push_back(level);
		tx_bytes.push_back(dir);
		tx_bytes.push_back(en);
		send_frame(ice_bus_pkg::TYPE_GPIO_WRITE);
		exp_pay.delete();
		expect_frame(ice_bus_pkg::TYPE_GPIO_WRITE);
	endtask

	task automatic gpio_write_read();
		write_gpio(8'hA5, 8'h0F, 8'h00);
		check_eq("gpio_out", gpio_out, 8'hA5);
		check_eq("gpio_oe", gpio_oe, 8'h0F);
		gpio_in = 8'h3C;
		tx_bytes.delete();
		send_frame(ice_bus_pkg::TYPE_GPIO_READ);
		exp_pay.delete();
		exp_pay.push_back(8'h3C);
		expect_frame(ice_bus_pkg::TYPE_GPIO_READ);
	endtask

	task automatic pin_change_event();
		int n;
		// Different level and direction so the later rewrite shows up
		write_gpio(8'h5A, 8'hF0, 8'h04);
		// Pin 2 enabled, so this toggle queues a snapshot
		gpio_in = gpio_in ^ 8'h04;
		exp_pay.delete();
		exp_pay.push_back(gpio_in);
		expect_frame(ice_bus_pkg::TYPE_GPIO_EVENT);
		// Pin 5 is not enabled
		gpio_in = gpio_in ^ 8'h20;
		for (n = 0; n < QUIET_CYCLES; n++) begin
			@(negedge clk);
			check_eq("host_tx_valid", host_tx_valid, 1'b0);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic unknown_type_nak();
		tx_bytes.delete();
		tx_bytes.push_back(8'h11);
		send_frame(8'h7A);
		exp_pay.delete();
		exp_pay.push_back(8'h7A);
		expect_frame(ice_bus_pkg::TYPE_NAK);
		// Bus still usable after a NAK
		version_query();
	endtask

	task automatic back_pressure_repeat();
		bp_mode = 1'b1;
		version_query();
		gpio_write_read();
		bp_mode = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		host_rx_data = 8'h00;
		host_rx_valid = 1'b0;
		host_tx_ready = 1'b0;
		gpio_in = 8'h00;
		exp_evt = 8'h00;
		lfsr = 16'd51;
		bp_mode = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_eq("host_tx_valid", host_tx_valid, 1'b0);
		check_eq("host_rx_ready", host_rx_ready, 1'b1);
		check_eq("power_sw", power_sw, 3'd0);
		check_eq("gpio_out", gpio_out, 8'h00);
		check_eq("gpio_oe", gpio_oe, 8'h00);
		@(posedge clk);
		#1;
		version_query();
		power_switch();
		gpio_write_read();
		pin_change_event();
		unknown_type_nak();
		back_pressure_repeat();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- build.f
verilog/ice_bus_pkg.sv
verilog/sync_fifo.sv
verilog/ice_bus_controller.sv
verilog/basics_int.sv
verilog/gpio_int.sv
verilog/response_arbiter.sv
verilog/ice_bus.sv
sim/ice_bus_tb.sv

//--- Bender.yml
package:
  name: ice_bus

sources:
  - verilog/ice_bus_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/ice_bus_controller.sv
  - verilog/basics_int.sv
  - verilog/gpio_int.sv
  - verilog/response_arbiter.sv
  - verilog/ice_bus.sv
  - target: simulation
    files:
      - sim/ice_bus_tb.sv
